// ==== Bender.yml ====
package:
  name: uart_rx

sources:
  - files:
      - verilog/uart_rx_cfg_pkg.sv
      - verilog/uart_rx_types_pkg.sv
      - verilog/rx_input_filter.sv
      - verilog/rx_control.sv
      - verilog/rx_shift_parity.sv
      - verilog/rx_status.sv
      - verilog/uart_rx_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/uart_rx_tb.sv

// ==== bench/uart_rx_tasks.svh ====
`ifndef UART_RX_TASKS_SVH
`define UART_RX_TASKS_SVH

// --------------------
// helpers
// --------------------
task automatic abort_run(input string msg);
  $display("%s", msg);
  $display("TEST FAILED");
  $fatal(1, "stopping at the first failure");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp)
    abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
endtask

// galois form with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic logic [7:0] rand_byte();
  logic [7:0] b;
  for (int i = 0; i < 8; i++)
  begin
    b[i] = lfsr_state[0];  // one step per bit
    lfsr_state = lfsr_next(lfsr_state);
  end
  return b;
endfunction

// parity bit for an even count of ones or an odd count when odd is set
function automatic logic parity_bit(input logic [7:0] data, input int n_data, input logic odd);
  logic p;
  p = odd;
  for (int i = 0; i < n_data; i++)
    p ^= data[i];
  return p;
endfunction

// returns just after the edge that carries a tick
task automatic wait_tick();
  @(posedge clk);
  while (!baud_tick)
    @(posedge clk);
  #1;
endtask

// 16 ticks per bit with an optional one tick low pulse in the middle
task automatic drive_bit(input logic value, input logic glitch);
  for (int t = 0; t < 16; t++)
  begin
    rx = (glitch && t == 8) ? 1'b0 : value;
    wait_tick();
  end
endtask

task automatic send_frame(input logic [7:0] data, input int n_data, input logic with_par,
                          input logic par, input logic stop, input int glitch_idx);
  wait_tick();
  drive_bit(1'b0, 1'b0);  // start bit
  for (int i = 0; i < n_data; i++)
    drive_bit(data[i], i == glitch_idx);
  if (with_par)
    drive_bit(par, 1'b0);
  drive_bit(stop, 1'b0);
  rx = 1'b1;
  repeat (8) wait_tick();  // idle gap
endtask

task automatic set_format(input logic b8, input logic par_en, input logic odd);
  bit8       = b8;
  parity_en  = par_en;
  odd_n_even = odd;
endtask

task automatic wait_full();
  int waited;
  waited = 0;
  while (!receive_full)
  begin
    @(posedge clk);
    #1;
    waited++;
    if (waited > FRAME_CYCLES)
      abort_run("receive_full did not rise after a complete frame");
  end
endtask

task automatic pulse_read();
  read_rx_byte = 1'b1;
  @(posedge clk);
  #1;
  read_rx_byte = 1'b0;
endtask

task automatic pulse_clear_parity();
  clear_parity = 1'b1;
  @(posedge clk);
  #1;
  clear_parity = 1'b0;
endtask

task automatic pulse_clear_framing();
  clear_framing_error = 1'b1;
  @(posedge clk);
  #1;
  clear_framing_error = 1'b0;
endtask

// --------------------
// tests
// --------------------
task automatic check_reset_state();
  check_value("rx_byte", rx_byte, 0);
  check_value("receive_full", receive_full, 0);
  check_value("overflow", overflow, 0);
  check_value("parity_err", parity_err, 0);
  check_value("framing_error", framing_error, 0);
endtask

task automatic recv_random_bytes();
  logic [7:0] data;
  set_format(1'b1, 1'b0, 1'b0);  // 8N1
  for (int n = 0; n < 4; n++)
  begin
    data = rand_byte();
    send_frame(data, 8, 1'b0, 1'b0, 1'b1, -1);
    wait_full();
    check_value("rx_byte", rx_byte, data);
    pulse_read();
    check_value("receive_full", receive_full, 0);
  end
endtask

task automatic check_7bit_parity();
  logic [7:0] data;
  for (int odd = 0; odd < 2; odd++)
  begin
    set_format(1'b0, 1'b1, odd[0]);
    data = rand_byte();
    send_frame(data, 7, 1'b1, parity_bit(data, 7, odd[0]), 1'b1, -1);
    wait_full();
    check_value("rx_byte", rx_byte, data & 8'h7f);
    check_value("parity_err", parity_err, 0);
    pulse_read();
  end
endtask

task automatic detect_bad_parity();
  logic [7:0] data;
  set_format(1'b1, 1'b1, 1'b1);
  data = rand_byte();
  send_frame(data, 8, 1'b1, ~parity_bit(data, 8, 1'b1), 1'b1, -1);
  wait_full();
  check_value("rx_byte", rx_byte, data);
  check_value("parity_err", parity_err, 1);
  pulse_clear_parity();
  check_value("parity_err", parity_err, 0);
  pulse_read();
endtask

task automatic detect_overflow();
  logic [7:0] first;
  logic [7:0] second;
  set_format(1'b1, 1'b0, 1'b0);
  first  = rand_byte();
  second = rand_byte();
  if (second == first)
    second = ~first;
  send_frame(first, 8, 1'b0, 1'b0, 1'b1, -1);
  wait_full();
  send_frame(second, 8, 1'b0, 1'b0, 1'b1, -1);
  check_value("overflow", overflow, 1);
  check_value("receive_full", receive_full, 1);
  check_value("rx_byte", rx_byte, first);  // second frame dropped
  pulse_read();
  check_value("receive_full", receive_full, 0);
  check_value("overflow", overflow, 0);
endtask

task automatic detect_framing_error();
  logic [7:0] data;
  set_format(1'b1, 1'b0, 1'b0);
  data = rand_byte();
  send_frame(data, 8, 1'b0, 1'b0, 1'b0, -1);  // stop bit held low
  wait_full();
  check_value("framing_error", framing_error, 1);
  check_value("rx_byte", rx_byte, data);
  pulse_clear_framing();
  check_value("framing_error", framing_error, 0);
  pulse_read();
  data = rand_byte();
  send_frame(data, 8, 1'b0, 1'b0, 1'b1, -1);
  wait_full();
  check_value("rx_byte", rx_byte, data);
  check_value("framing_error", framing_error, 0);
  pulse_read();
endtask

task automatic reject_glitch();
  logic [7:0] data;
  set_format(1'b1, 1'b0, 1'b0);
  data = rand_byte() | 8'h08;  // bit 3 high to carry the glitch
  send_frame(data, 8, 1'b0, 1'b0, 1'b1, 3);
  wait_full();
  check_value("rx_byte", rx_byte, data);
  pulse_read();
endtask

`endif

// ==== bench/uart_rx_tb.sv ====
`default_nettype none

module uart_rx_tb;

  localparam int unsigned TICK_DIV       = 4;                   // clocks per baud tick
  localparam int unsigned N_FRAMES       = 12;                  // frames over all tests
  localparam int unsigned FRAME_CYCLES   = 11 * 16 * TICK_DIV;  // longest frame in clocks
  localparam int unsigned TIMEOUT_CYCLES = N_FRAMES * FRAME_CYCLES + 2000;
  localparam logic [15:0] LFSR_SEED      = 16'd20558;

  logic       clk;
  logic       aresetn;
  logic       baud_tick;
  logic       rx;
  logic       bit8;
  logic       parity_en;
  logic       odd_n_even;
  logic       read_rx_byte;
  logic       clear_parity;
  logic       clear_framing_error;
  logic [7:0] rx_byte;
  logic       receive_full;
  logic       overflow;
  logic       parity_err;
  logic       framing_error;

  int unsigned tick_div;
  int unsigned cycle_cnt;
  logic [15:0] lfsr_state;  // test data source

  // --------------------
  // clock and baud tick
  // --------------------
  always #5 clk = ~clk;

  // one clk wide strobe every TICK_DIV clocks
  always @(posedge clk)
  begin
    #1;
    tick_div = (tick_div == TICK_DIV - 1) ? 0 : tick_div + 1;
    baud_tick = (tick_div == TICK_DIV - 1);
  end

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES)
      abort_run("run exceeded its cycle limit, the receiver stopped responding");
  end

  // --------------------
  // DUT
  // --------------------
  uart_rx_top uart_rx_top_i (
    .clk                 (clk),
    .aresetn             (aresetn),
    .baud_tick           (baud_tick),
    .rx                  (rx),
    .bit8                (bit8),
    .parity_en           (parity_en),
    .odd_n_even          (odd_n_even),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

  `include "uart_rx_tasks.svh"

  // --------------------
  // test sequence
  // --------------------
  initial
  begin
    clk                 = 1'b0;
    aresetn             = 1'b0;
    baud_tick           = 1'b0;
    tick_div            = 0;
    cycle_cnt           = 0;
    rx                  = 1'b1;  // idle line
    bit8                = 1'b1;
    parity_en           = 1'b0;
    odd_n_even          = 1'b0;
    read_rx_byte        = 1'b0;
    clear_parity        = 1'b0;
    clear_framing_error = 1'b0;
    lfsr_state          = LFSR_SEED;

    repeat (8) @(posedge clk);
    #1;
    aresetn = 1'b1;

    check_reset_state();
    recv_random_bytes();
    check_7bit_parity();
    detect_bad_parity();
    detect_overflow();
    detect_framing_error();
    reject_glitch();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
verilog/uart_rx_cfg_pkg.sv
verilog/uart_rx_types_pkg.sv
verilog/rx_input_filter.sv
verilog/rx_control.sv
verilog/rx_shift_parity.sv
verilog/rx_status.sv
verilog/uart_rx_top.sv
bench/uart_rx_tb.sv

// ==== verilog/rx_control.sv ====
`default_nettype none

module rx_control (
  input  wire                           clk,
  input  wire                           aresetn,
  input  wire                           baud_tick,
  input  wire                           rx_filtered,
  input  wire                           bit8,
  input  wire                           parity_en,
  output logic                          shift_en,
  output logic                          frame_clear,
  output logic                          frame_done,
  output logic                          stop_check,
  output uart_rx_types_pkg::frame_fmt_t frame_fmt
);

  uart_rx_types_pkg::rx_state_t            state;
  logic [uart_rx_cfg_pkg::TICK_CNT_W-1:0]  tick_cnt;
  logic [uart_rx_cfg_pkg::BIT_CNT_W-1:0]   bit_cnt;     // bits sampled so far
  logic [uart_rx_cfg_pkg::BIT_CNT_W-1:0]   last_idx;    // index of the final bit
  logic [uart_rx_cfg_pkg::BIT_CNT_W-1:0]   frame_bits;
  logic                                    start_ok;
  logic                                    tick_clr;

  assign frame_fmt = uart_rx_types_pkg::frame_fmt_t'({bit8, parity_en});

  // bits after the start bit with parity included
  always_comb
  begin
    case (frame_fmt)
      uart_rx_types_pkg::fmt_7n: frame_bits = uart_rx_cfg_pkg::BIT_CNT_W'(7);
      uart_rx_types_pkg::fmt_8p: frame_bits = uart_rx_cfg_pkg::BIT_CNT_W'(9);
      default:                   frame_bits = uart_rx_cfg_pkg::BIT_CNT_W'(8);
    endcase
  end

  assign start_ok = (state == uart_rx_types_pkg::st_idle) &&
                    (tick_cnt == uart_rx_cfg_pkg::START_MID);

  // --------------------
  // tick counter
  // --------------------
  always_comb
  begin
    case (state)
      uart_rx_types_pkg::st_idle:
        tick_clr = rx_filtered || (tick_cnt == uart_rx_cfg_pkg::START_MID);
      uart_rx_types_pkg::st_wait:
        tick_clr = rx_filtered || (tick_cnt == uart_rx_cfg_pkg::WAIT_LIMIT);
      default:
        tick_clr = 1'b0;  // wraps once per bit
    endcase
  end

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      tick_cnt <= '0;
    end
    else if (baud_tick)
    begin
      tick_cnt <= tick_clr ? '0 : tick_cnt + 1'b1;
    end
  end

  // --------------------
  // receive FSM
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state <= uart_rx_types_pkg::st_idle;
    end
    else if (baud_tick)
    begin
      case (state)
        uart_rx_types_pkg::st_idle:
        begin
          if (start_ok)
            state <= uart_rx_types_pkg::st_data;
        end
        uart_rx_types_pkg::st_data:
        begin
          if (frame_done)
            state <= uart_rx_types_pkg::st_stop;
        end
        uart_rx_types_pkg::st_stop:
        begin
          if (tick_cnt == uart_rx_cfg_pkg::STOP_END)
            state <= uart_rx_types_pkg::st_wait;
        end
        default:
        begin
          if (rx_filtered || (tick_cnt == uart_rx_cfg_pkg::WAIT_LIMIT))
            state <= uart_rx_types_pkg::st_idle;
        end
      endcase
    end
  end

  // bit counter and frame length
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      bit_cnt  <= '0;
      last_idx <= uart_rx_cfg_pkg::BIT_CNT_W'(8);
    end
    else
    begin
      if (frame_clear)
        bit_cnt <= '0;
      else if (shift_en)
        bit_cnt <= bit_cnt + 1'b1;
      if (baud_tick && start_ok)
        last_idx <= frame_bits - 1'b1;  // format is fixed from here on
    end
  end

  // --------------------
  // strobes
  // --------------------
  assign shift_en    = baud_tick && (state == uart_rx_types_pkg::st_data) &&
                       (tick_cnt == uart_rx_cfg_pkg::SAMPLE_POINT);
  assign frame_clear = baud_tick && (state == uart_rx_types_pkg::st_idle);
  assign frame_done  = shift_en && (bit_cnt == last_idx);
  assign stop_check  = baud_tick && (state == uart_rx_types_pkg::st_stop) &&
                       (tick_cnt == uart_rx_cfg_pkg::STOP_CHECK);

  // sampling stays inside a frame and never runs past its last bit
  a_no_shift_in_idle: assert property (@(posedge clk) disable iff (!aresetn)
    shift_en |-> (state != uart_rx_types_pkg::st_idle) && (bit_cnt <= last_idx));

  // the final sample hands over to the stop bit
  a_done_ends_data: assert property (@(posedge clk) disable iff (!aresetn)
    frame_done |-> shift_en ##1 (state == uart_rx_types_pkg::st_stop));

endmodule

`default_nettype wire

// ==== verilog/rx_input_filter.sv ====
`default_nettype none

module rx_input_filter (
  input  wire  clk,
  input  wire  aresetn,
  input  wire  baud_tick,
  input  wire  rx,
  output logic rx_filtered
);

  logic [uart_rx_cfg_pkg::FILTER_LEN-1:0] hist;  // newest sample at the top

  // --------------------
  // sample history
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      hist <= '1;  // idle line is high
    end
    else if (baud_tick)
    begin
      hist <= {rx, hist[uart_rx_cfg_pkg::FILTER_LEN-1:1]};
    end
  end

  // majority vote over the history
  always_comb
  begin : vote
    int unsigned ones;
    ones = 0;
    for (int i = 0; i < uart_rx_cfg_pkg::FILTER_LEN; i++)
    begin
      ones += hist[i];
    end
    rx_filtered = (ones > uart_rx_cfg_pkg::FILTER_LEN / 2);
  end

endmodule

`default_nettype wire

// ==== verilog/rx_shift_parity.sv ====
`default_nettype none

module rx_shift_parity (
  input  wire                                 clk,
  input  wire                                 aresetn,
  input  wire                                 rx_filtered,
  input  wire                                 shift_en,
  input  wire                                 frame_clear,
  input  wire                                 frame_done,
  input  var  uart_rx_types_pkg::frame_fmt_t  frame_fmt,
  input  wire                                 odd_n_even,
  output logic [uart_rx_cfg_pkg::DATA_W-1:0]  rx_data,
  output logic                                parity_fail
);

  logic [uart_rx_cfg_pkg::SHIFT_W-1:0] shift_q;
  logic [uart_rx_cfg_pkg::SHIFT_W-1:0] shift_d;     // shift_q with the current bit in
  logic                                par_acc;     // xor of data bits so far
  logic                                has_parity;
  logic                                is_8bit;

  assign has_parity = (frame_fmt == uart_rx_types_pkg::fmt_7p) ||
                      (frame_fmt == uart_rx_types_pkg::fmt_8p);
  assign is_8bit    = (frame_fmt == uart_rx_types_pkg::fmt_8n) ||
                      (frame_fmt == uart_rx_types_pkg::fmt_8p);

  // --------------------
  // shift register
  // --------------------
  // LSB first with the entry point set by the frame length
  always_comb
  begin
    case (frame_fmt)
      uart_rx_types_pkg::fmt_7n:
        shift_d = {2'b00, rx_filtered, shift_q[uart_rx_cfg_pkg::DATA_W-2:1]};
      uart_rx_types_pkg::fmt_8p:
        shift_d = {rx_filtered, shift_q[uart_rx_cfg_pkg::SHIFT_W-1:1]};
      default:
        shift_d = {1'b0, rx_filtered, shift_q[uart_rx_cfg_pkg::DATA_W-1:1]};
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (frame_clear)
      shift_q <= '0;
    else if (shift_en)
      shift_q <= shift_d;
  end

  // running parity
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      par_acc <= 1'b0;
    end
    else if (frame_clear)
    begin
      par_acc <= 1'b0;
    end
    else if (shift_en)
    begin
      par_acc <= par_acc ^ rx_filtered;
    end
  end

  // --------------------
  // frame result
  // --------------------
  // last bit is still on the line at frame_done so take it from shift_d
  assign rx_data = {shift_d[uart_rx_cfg_pkg::DATA_W-1] & is_8bit,
                    shift_d[uart_rx_cfg_pkg::DATA_W-2:0]};

  // parity bit is the one being sampled right now
  assign parity_fail = frame_done && has_parity && (par_acc ^ rx_filtered ^ odd_n_even);

endmodule

`default_nettype wire

// ==== verilog/rx_status.sv ====
`default_nettype none

module rx_status (
  input  wire                                clk,
  input  wire                                aresetn,
  input  wire                                rx_filtered,
  input  wire                                frame_done,
  input  wire                                stop_check,
  input  wire [uart_rx_cfg_pkg::DATA_W-1:0]  rx_data,
  input  wire                                parity_fail,
  input  wire                                read_rx_byte,
  input  wire                                clear_parity,
  input  wire                                clear_framing_error,
  output logic [uart_rx_cfg_pkg::DATA_W-1:0] rx_byte,
  output logic                               receive_full,
  output logic                               overflow,
  output logic                               parity_err,
  output logic                               framing_error
);

  logic load_byte;
  logic ovf_set;

  assign load_byte = frame_done && !receive_full;
  assign ovf_set   = frame_done && receive_full;  // old byte is kept

  // --------------------
  // byte register
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      rx_byte <= '0;
    else if (load_byte)
      rx_byte <= rx_data;
  end

  // --------------------
  // flags
  // --------------------
  // a set beats a clear in the same cycle
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      receive_full  <= 1'b0;
      overflow      <= 1'b0;
      parity_err    <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (frame_done)
        receive_full <= 1'b1;
      else if (read_rx_byte)
        receive_full <= 1'b0;

      if (ovf_set)
        overflow <= 1'b1;
      else if (read_rx_byte)
        overflow <= 1'b0;

      if (frame_done && parity_fail)
        parity_err <= 1'b1;
      else if (clear_parity)
        parity_err <= 1'b0;

      if (stop_check && !rx_filtered)
        framing_error <= 1'b1;  // stop bit seen low
      else if (clear_framing_error)
        framing_error <= 1'b0;
    end
  end

  a_overflow_needs_full: assert property (@(posedge clk) disable iff (!aresetn)
    overflow |-> receive_full);

endmodule

`default_nettype wire

// ==== verilog/uart_rx_cfg_pkg.sv ====
`default_nettype none

package uart_rx_cfg_pkg;

  // --------------------
  // oversampling
  // --------------------
  localparam int unsigned OVERSAMPLE = 16;                  // baud ticks per bit
  localparam int unsigned TICK_CNT_W = $clog2(OVERSAMPLE);

  // sample points within one bit period
  localparam int unsigned START_MID    = 8;   // start bit confirmed here
  localparam int unsigned SAMPLE_POINT = 15;  // data and parity bits
  localparam int unsigned STOP_CHECK   = 14;  // stop bit level check
  localparam int unsigned STOP_END     = 15;
  localparam int unsigned WAIT_LIMIT   = 6;   // max ticks waiting for a high line

  // --------------------
  // widths
  // --------------------
  localparam int unsigned DATA_W     = 8;
  localparam int unsigned SHIFT_W    = DATA_W + 1;  // data plus parity
  localparam int unsigned BIT_CNT_W  = 4;
  localparam int unsigned FILTER_LEN = 3;           // majority voter depth

endpackage

`default_nettype wire

// ==== verilog/uart_rx_top.sv ====
`default_nettype none

module uart_rx_top (
  input  wire                                clk,
  input  wire                                aresetn,
  input  wire                                baud_tick,   // 16x bit rate
  input  wire                                rx,
  input  wire                                bit8,
  input  wire                                parity_en,
  input  wire                                odd_n_even,  // 1 for odd parity
  input  wire                                read_rx_byte,
  input  wire                                clear_parity,
  input  wire                                clear_framing_error,
  output logic [uart_rx_cfg_pkg::DATA_W-1:0] rx_byte,
  output logic                               receive_full,
  output logic                               overflow,
  output logic                               parity_err,
  output logic                               framing_error
);

  logic                                rx_filtered;
  logic                                shift_en;
  logic                                frame_clear;
  logic                                frame_done;
  logic                                stop_check;
  uart_rx_types_pkg::frame_fmt_t       frame_fmt;
  logic [uart_rx_cfg_pkg::DATA_W-1:0]  rx_data;
  logic                                parity_fail;

  // --------------------
  // front end and control
  // --------------------
  rx_input_filter rx_input_filter_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .rx_filtered (rx_filtered)
  );

  rx_control rx_control_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx_filtered (rx_filtered),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .shift_en    (shift_en),
    .frame_clear (frame_clear),
    .frame_done  (frame_done),
    .stop_check  (stop_check),
    .frame_fmt   (frame_fmt)
  );

  // --------------------
  // datapath
  // --------------------
  rx_shift_parity rx_shift_parity_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .rx_filtered (rx_filtered),
    .shift_en    (shift_en),
    .frame_clear (frame_clear),
    .frame_done  (frame_done),
    .frame_fmt   (frame_fmt),
    .odd_n_even  (odd_n_even),
    .rx_data     (rx_data),
    .parity_fail (parity_fail)
  );

  rx_status rx_status_i (
    .clk                 (clk),
    .aresetn             (aresetn),
    .rx_filtered         (rx_filtered),
    .frame_done          (frame_done),
    .stop_check          (stop_check),
    .rx_data             (rx_data),
    .parity_fail         (parity_fail),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

endmodule

`default_nettype wire

// ==== verilog/uart_rx_types_pkg.sv ====
`default_nettype none

package uart_rx_types_pkg;

  // receive FSM
  typedef enum logic [1:0] {
    st_idle = 2'd0,  // hunting for a start bit
    st_data = 2'd1,  // data and parity bits
    st_stop = 2'd2,
    st_wait = 2'd3   // line still low after the stop bit
  } rx_state_t;

  // frame format, coded as {bit8, parity_en}
  typedef enum logic [1:0] {
    fmt_7n = 2'b00,
    fmt_7p = 2'b01,
    fmt_8n = 2'b10,
    fmt_8p = 2'b11
  } frame_fmt_t;

endpackage

`default_nettype wire
